/* src/id_consts.svh */
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// Datapath widths
`define ID_DATA_W   24
`define ID_ADDR_W   24

// Opcode field and its place in the instruction word
`define ID_OPC_W    8
`define ID_OPC_HI   23
`define ID_OPC_LO   16

// Condition code and register index widths
`define ID_CC_W     4
`define ID_GP_W     4
`define ID_SR_W     2

// Immediate widths, all taken from bit 0 upwards
`define ID_IMM12_W  12
`define ID_IMM14_W  14
`define ID_IMM16_W  16

`endif

/* src/id_pkg.sv */
`default_nettype none

`include "id_consts.svh"

package id_pkg;

    // Opcode map, the upper nibble is the class
    typedef enum logic [`ID_OPC_W-1:0] {
        // Class 0, unsigned register forms
        MOVur   = 8'h00,
        ADDur   = 8'h01,
        SUBur   = 8'h02,
        NOTur   = 8'h03,
        ANDur   = 8'h04,
        ORur    = 8'h05,
        XORur   = 8'h06,
        SHLur   = 8'h07,
        SHRur   = 8'h08,
        ROLur   = 8'h09,
        RORur   = 8'h0A,
        CMPur   = 8'h0B,
        TSTur   = 8'h0C,
        MCCur   = 8'h0D,
        // Class 1, unsigned immediate forms
        MOVui   = 8'h10,
        ADDui   = 8'h11,
        SUBui   = 8'h12,
        ANDui   = 8'h13,
        ORui    = 8'h14,
        XORui   = 8'h15,
        SHLui   = 8'h16,
        SHRui   = 8'h17,
        ROLui   = 8'h18,
        RORui   = 8'h19,
        CMPui   = 8'h1A,
        LUIui   = 8'h1B,
        // Class 2, signed register forms
        ADDsr   = 8'h20,
        SUBsr   = 8'h21,
        SHRsr   = 8'h22,
        NEGsr   = 8'h23,
        CMPsr   = 8'h24,
        TSTsr   = 8'h25,
        // Class 3, signed immediate forms
        MOVsi   = 8'h30,
        ADDsi   = 8'h31,
        SUBsi   = 8'h32,
        SHRsi   = 8'h33,
        CMPsi   = 8'h34,
        MCCsi   = 8'h35,
        // Class 4, branches
        JCCui   = 8'h40,
        BCCsr   = 8'h41,
        BCCso   = 8'h42,
        BALso   = 8'h43,
        // Class 5, special registers
        SRMOVur = 8'h50,
        SRADDsi = 8'h51,
        SRSUBsi = 8'h52,
        SRLDso  = 8'h53,
        SRSTso  = 8'h54,
        // Class 6, system
        SYSCALL = 8'h60,
        KRET    = 8'h61
    } opc_e;

    // Fixed SR indices
    localparam logic [`ID_SR_W-1:0] SR_IDX_FL = 2'd2;
    localparam logic [`ID_SR_W-1:0] SR_IDX_LR = 2'd3;

    // Control bundle from the classifier
    typedef struct packed {
        logic [`ID_OPC_W-1:0] opc;
        logic                 sgn_en;
        logic                 imm_en;
        logic                 has_src_gp;
        logic                 tgt_gp_we;
        logic                 has_src_sr;
        logic                 tgt_sr_we;
    } id_ctrl_t;

    // Extracted operand fields
    typedef struct packed {
        logic [`ID_IMM12_W-1:0] imm12;
        logic [`ID_IMM14_W-1:0] imm14;
        logic [`ID_IMM16_W-1:0] imm16;
        logic [`ID_CC_W-1:0]    cc;
        logic [`ID_GP_W-1:0]    src_gp;
        logic [`ID_GP_W-1:0]    tgt_gp;
        logic [`ID_SR_W-1:0]    src_sr;
        logic [`ID_SR_W-1:0]    tgt_sr;
    } id_field_t;

    // Raw values carried alongside the decode
    typedef struct packed {
        logic [`ID_ADDR_W-1:0] pc;
        logic [`ID_DATA_W-1:0] instr;
    } id_pass_t;

endpackage

`default_nettype wire

/* src/id_classify.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_consts.svh"

module id_classify (
    input  wire logic [`ID_DATA_W-1:0] instr,
    output id_pkg::id_ctrl_t           ctrl,
    output logic                       has_tgt_gp,
    output logic                       has_tgt_sr,
    output logic                       uses_flags
);

    id_pkg::opc_e opc;

    // Per-opcode decode terms
    logic sgn;
    logic imm;
    logic flags;
    logic gp_we;
    logic gp_tgt_only;
    logic gp_src;
    logic sr_src;
    logic sr_we;
    logic sr_tgt_only;

    assign opc = id_pkg::opc_e'(instr[`ID_OPC_HI:`ID_OPC_LO]);

    always_comb begin
        sgn         = 1'b0;
        imm         = 1'b0;
        flags       = 1'b0;
        gp_we       = 1'b0;
        gp_tgt_only = 1'b0;
        gp_src      = 1'b0;
        sr_src      = 1'b0;
        sr_we       = 1'b0;
        sr_tgt_only = 1'b0;
        case (opc)
            // Two-operand unsigned ALU ops read DRs and write DRt
            id_pkg::MOVur, id_pkg::ADDur, id_pkg::SUBur, id_pkg::ANDur,
            id_pkg::ORur, id_pkg::XORur, id_pkg::SHLur, id_pkg::SHRur,
            id_pkg::ROLur, id_pkg::RORur: begin
                gp_we  = 1'b1;
                gp_src = 1'b1;
            end
            id_pkg::NOTur: gp_we = 1'b1;
            id_pkg::CMPur: begin
                gp_tgt_only = 1'b1;
                gp_src      = 1'b1;
            end
            id_pkg::TSTur: gp_tgt_only = 1'b1;
            // Conditional move reads the flags register implicitly
            id_pkg::MCCur: begin
                gp_we  = 1'b1;
                gp_src = 1'b1;
                flags  = 1'b1;
            end
            id_pkg::MOVui, id_pkg::ADDui, id_pkg::SUBui, id_pkg::ANDui,
            id_pkg::ORui, id_pkg::XORui, id_pkg::SHLui, id_pkg::SHRui,
            id_pkg::ROLui, id_pkg::RORui, id_pkg::LUIui: begin
                imm   = 1'b1;
                gp_we = 1'b1;
            end
            id_pkg::CMPui: begin
                imm         = 1'b1;
                gp_tgt_only = 1'b1;
            end
            id_pkg::ADDsr, id_pkg::SUBsr, id_pkg::SHRsr: begin
                sgn    = 1'b1;
                gp_we  = 1'b1;
                gp_src = 1'b1;
            end
            id_pkg::NEGsr: begin
                sgn   = 1'b1;
                gp_we = 1'b1;
            end
            id_pkg::CMPsr: begin
                sgn         = 1'b1;
                gp_tgt_only = 1'b1;
                gp_src      = 1'b1;
            end
            id_pkg::TSTsr: begin
                sgn         = 1'b1;
                gp_tgt_only = 1'b1;
            end
            id_pkg::MOVsi, id_pkg::ADDsi, id_pkg::SUBsi, id_pkg::SHRsi: begin
                sgn   = 1'b1;
                imm   = 1'b1;
                gp_we = 1'b1;
            end
            id_pkg::CMPsi: begin
                sgn = 1'b1;
                imm = 1'b1;
            end
            id_pkg::MCCsi: begin
                sgn   = 1'b1;
                imm   = 1'b1;
                gp_we = 1'b1;
                flags = 1'b1;
            end
            // All branches test the flags
            id_pkg::JCCui: begin
                imm   = 1'b1;
                flags = 1'b1;
            end
            // BCCsr takes its signed offset from DRt
            id_pkg::BCCsr: begin
                sgn         = 1'b1;
                flags       = 1'b1;
                gp_tgt_only = 1'b1;
            end
            id_pkg::BCCso, id_pkg::BALso: begin
                sgn   = 1'b1;
                imm   = 1'b1;
                flags = 1'b1;
            end
            id_pkg::SRMOVur: begin
                sr_src = 1'b1;
                sr_we  = 1'b1;
            end
            id_pkg::SRADDsi, id_pkg::SRSUBsi: begin
                sgn   = 1'b1;
                imm   = 1'b1;
                sr_we = 1'b1;
            end
            id_pkg::SRLDso: begin
                sgn    = 1'b1;
                imm    = 1'b1;
                sr_src = 1'b1;
                sr_we  = 1'b1;
            end
            // Store names the base SR as target but does not write it
            id_pkg::SRSTso: begin
                sgn         = 1'b1;
                imm         = 1'b1;
                sr_src      = 1'b1;
                sr_tgt_only = 1'b1;
            end
            // SYSCALL saves the return address into LR
            id_pkg::SYSCALL: begin
                imm   = 1'b1;
                sr_we = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign uses_flags = flags;
    assign has_tgt_gp = gp_we | gp_tgt_only;
    assign has_tgt_sr = sr_we | sr_tgt_only;

    assign ctrl = '{
        opc:        opc,
        sgn_en:     sgn,
        imm_en:     imm,
        has_src_gp: gp_src,
        tgt_gp_we:  gp_we,
        has_src_sr: sr_src | flags,
        tgt_sr_we:  sr_we
    };

endmodule

`default_nettype wire

/* src/id_fields.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_consts.svh"

module id_fields (
    input  wire logic [`ID_DATA_W-1:0] instr,
    input  wire logic                  has_tgt_gp,
    input  wire logic                  has_tgt_sr,
    input  wire logic                  uses_flags,
    output id_pkg::id_field_t          fields
);

    id_pkg::opc_e opc;

    logic [`ID_IMM12_W-1:0] imm12;
    logic [`ID_IMM14_W-1:0] imm14;
    logic [`ID_IMM16_W-1:0] imm16;
    logic [`ID_CC_W-1:0]    cc;
    logic [`ID_GP_W-1:0]    tgt_gp;
    logic [`ID_SR_W-1:0]    src_sr;
    logic [`ID_SR_W-1:0]    tgt_sr;

    assign opc = id_pkg::opc_e'(instr[`ID_OPC_HI:`ID_OPC_LO]);

    // Immediate selection, unused widths stay zero
    always_comb begin
        imm12 = '0;
        imm14 = '0;
        imm16 = '0;
        case (opc)
            id_pkg::MOVui, id_pkg::ADDui, id_pkg::SUBui, id_pkg::ANDui,
            id_pkg::ORui, id_pkg::XORui, id_pkg::SHLui, id_pkg::SHRui,
            id_pkg::ROLui, id_pkg::RORui, id_pkg::CMPui, id_pkg::LUIui,
            id_pkg::MOVsi, id_pkg::ADDsi, id_pkg::SUBsi, id_pkg::SHRsi,
            id_pkg::CMPsi, id_pkg::MCCsi,
            id_pkg::JCCui, id_pkg::BCCso,
            id_pkg::SRLDso, id_pkg::SRSTso, id_pkg::SYSCALL: begin
                imm12 = instr[`ID_IMM12_W-1:0];
            end
            id_pkg::SRADDsi, id_pkg::SRSUBsi: begin
                imm14 = instr[`ID_IMM14_W-1:0];
            end
            id_pkg::BALso: begin
                imm16 = instr[`ID_IMM16_W-1:0];
            end
            default: begin
            end
        endcase
    end

    // Condition code position depends on the encoding
    always_comb begin
        case (opc)
            id_pkg::JCCui, id_pkg::BCCso: cc = instr[15:12];
            id_pkg::BCCsr, id_pkg::MCCsi: cc = instr[11:8];
            id_pkg::MCCur:                cc = instr[7:4];
            default:                      cc = '0;
        endcase
    end

    assign tgt_gp = has_tgt_gp ? instr[15:12] : '0;

    // Flag consumers always read SR[FL]
    assign src_sr = uses_flags ? id_pkg::SR_IDX_FL : instr[13:12];

    // SYSCALL and KRET work on LR whatever the encoding says
    always_comb begin
        if ((opc == id_pkg::SYSCALL) || (opc == id_pkg::KRET)) begin
            tgt_sr = id_pkg::SR_IDX_LR;
        end else if (has_tgt_sr) begin
            tgt_sr = instr[15:14];
        end else begin
            tgt_sr = '0;
        end
    end

    assign fields = '{
        imm12:  imm12,
        imm14:  imm14,
        imm16:  imm16,
        cc:     cc,
        src_gp: instr[11:8],
        tgt_gp: tgt_gp,
        src_sr: src_sr,
        tgt_sr: tgt_sr
    };

endmodule

`default_nettype wire

/* src/id_stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     iw_clk,
    input  wire logic     iw_rst,
    input  wire logic     flush,
    input  wire logic     stall,
    input  wire payload_t d,
    output payload_t      q
);

    // Flush beats stall and leaves an all-zero bubble
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* src/stg_id.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_consts.svh"

module stg_id (
    input  wire logic                   iw_clk,
    input  wire logic                   iw_rst,
    input  wire logic [`ID_ADDR_W-1:0]  pc,
    input  wire logic [`ID_DATA_W-1:0]  instr,
    input  wire logic                   flush,
    input  wire logic                   stall,
    output logic      [`ID_ADDR_W-1:0]  pc_q,
    output logic      [`ID_DATA_W-1:0]  instr_q,
    output logic      [`ID_OPC_W-1:0]   opc,
    output logic                        sgn_en,
    output logic                        imm_en,
    output logic      [`ID_IMM12_W-1:0] imm12_val,
    output logic      [`ID_IMM14_W-1:0] imm14_val,
    output logic      [`ID_IMM16_W-1:0] imm16_val,
    output logic      [`ID_CC_W-1:0]    cc,
    output logic                        has_src_gp,
    output logic      [`ID_GP_W-1:0]    src_gp,
    output logic      [`ID_GP_W-1:0]    tgt_gp,
    output logic                        tgt_gp_we,
    output logic                        has_src_sr,
    output logic      [`ID_SR_W-1:0]    src_sr,
    output logic      [`ID_SR_W-1:0]    tgt_sr,
    output logic                        tgt_sr_we
);

    id_pkg::id_ctrl_t  ctrl_d;
    id_pkg::id_ctrl_t  ctrl_q;
    id_pkg::id_field_t field_d;
    id_pkg::id_field_t field_q;
    id_pkg::id_pass_t  pass_d;
    id_pkg::id_pass_t  pass_q;

    // Classifier results shared with field extraction
    logic has_tgt_gp;
    logic has_tgt_sr;
    logic uses_flags;

    id_classify u_classify (
        .instr      (instr),
        .ctrl       (ctrl_d),
        .has_tgt_gp (has_tgt_gp),
        .has_tgt_sr (has_tgt_sr),
        .uses_flags (uses_flags)
    );

    id_fields u_fields (
        .instr      (instr),
        .has_tgt_gp (has_tgt_gp),
        .has_tgt_sr (has_tgt_sr),
        .uses_flags (uses_flags),
        .fields     (field_d)
    );

    assign pass_d = '{pc: pc, instr: instr};

    // Same flush and stall policy for all three bundles
    id_stage_reg #(.payload_t(id_pkg::id_ctrl_t)) u_ctrl_reg (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .flush  (flush),
        .stall  (stall),
        .d      (ctrl_d),
        .q      (ctrl_q)
    );

    id_stage_reg #(.payload_t(id_pkg::id_field_t)) u_field_reg (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .flush  (flush),
        .stall  (stall),
        .d      (field_d),
        .q      (field_q)
    );

    id_stage_reg #(.payload_t(id_pkg::id_pass_t)) u_pass_reg (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .flush  (flush),
        .stall  (stall),
        .d      (pass_d),
        .q      (pass_q)
    );

    assign pc_q       = pass_q.pc;
    assign instr_q    = pass_q.instr;
    assign opc        = ctrl_q.opc;
    assign sgn_en     = ctrl_q.sgn_en;
    assign imm_en     = ctrl_q.imm_en;
    assign has_src_gp = ctrl_q.has_src_gp;
    assign tgt_gp_we  = ctrl_q.tgt_gp_we;
    assign has_src_sr = ctrl_q.has_src_sr;
    assign tgt_sr_we  = ctrl_q.tgt_sr_we;
    assign imm12_val  = field_q.imm12;
    assign imm14_val  = field_q.imm14;
    assign imm16_val  = field_q.imm16;
    assign cc         = field_q.cc;
    assign src_gp     = field_q.src_gp;
    assign tgt_gp     = field_q.tgt_gp;
    assign src_sr     = field_q.src_sr;
    assign tgt_sr     = field_q.tgt_sr;

endmodule

`default_nettype wire

/* verification/stg_id_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module stg_id_assert (
    input wire logic              iw_clk,
    input wire logic              iw_rst,
    input wire logic              flush,
    input wire logic              stall,
    input wire id_pkg::id_ctrl_t  ctrl_q,
    input wire id_pkg::id_field_t field_q,
    input wire id_pkg::id_pass_t  pass_q,
    input wire logic              tgt_gp_we,
    input wire logic              tgt_sr_we
);

    // Number of failed assertions, read by the testbench
    int unsigned error_count = 0;

    // A flush leaves a bubble in all three registers, stall or not
    flush_bubble: assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> (ctrl_q == '0) && (field_q == '0) && (pass_q == '0))
        else begin
            $error("stage registers not cleared one cycle after flush");
            error_count++;
        end

    stall_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=> $stable(ctrl_q) && $stable(field_q) && $stable(pass_q))
        else begin
            $error("stage registers changed while stalled");
            error_count++;
        end

    // No register write may be requested during reset
    reset_quiet: assert property (@(posedge iw_clk)
        iw_rst |-> !tgt_gp_we && !tgt_sr_we)
        else begin
            $error("write enable active while reset is high");
            error_count++;
        end

endmodule

bind stg_id stg_id_assert u_assert (
    .iw_clk    (iw_clk),
    .iw_rst    (iw_rst),
    .flush     (flush),
    .stall     (stall),
    .ctrl_q    (ctrl_q),
    .field_q   (field_q),
    .pass_q    (pass_q),
    .tgt_gp_we (tgt_gp_we),
    .tgt_sr_we (tgt_sr_we)
);

`default_nettype wire

/* verification/tb_stg_id.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_consts.svh"

module tb_stg_id;

    localparam int NUM_RANDOM = 2000;
    localparam int POLL_LIMIT = 100;
    localparam logic [`ID_SR_W-1:0] FL_IDX = 2'd2;
    localparam logic [`ID_SR_W-1:0] LR_IDX = 2'd3;

    // Expected value of every registered output
    typedef struct packed {
        logic [`ID_ADDR_W-1:0]  pc_q;
        logic [`ID_DATA_W-1:0]  instr_q;
        logic [`ID_OPC_W-1:0]   opc;
        logic                   sgn_en;
        logic                   imm_en;
        logic [`ID_IMM12_W-1:0] imm12_val;
        logic [`ID_IMM14_W-1:0] imm14_val;
        logic [`ID_IMM16_W-1:0] imm16_val;
        logic [`ID_CC_W-1:0]    cc;
        logic                   has_src_gp;
        logic [`ID_GP_W-1:0]    src_gp;
        logic [`ID_GP_W-1:0]    tgt_gp;
        logic                   tgt_gp_we;
        logic                   has_src_sr;
        logic [`ID_SR_W-1:0]    src_sr;
        logic [`ID_SR_W-1:0]    tgt_sr;
        logic                   tgt_sr_we;
    } out_t;

    logic                   iw_clk;
    logic                   iw_rst;
    logic [`ID_ADDR_W-1:0]  pc;
    logic [`ID_DATA_W-1:0]  instr;
    logic                   flush;
    logic                   stall;
    logic [`ID_ADDR_W-1:0]  pc_q;
    logic [`ID_DATA_W-1:0]  instr_q;
    logic [`ID_OPC_W-1:0]   opc;
    logic                   sgn_en;
    logic                   imm_en;
    logic [`ID_IMM12_W-1:0] imm12_val;
    logic [`ID_IMM14_W-1:0] imm14_val;
    logic [`ID_IMM16_W-1:0] imm16_val;
    logic [`ID_CC_W-1:0]    cc;
    logic                   has_src_gp;
    logic [`ID_GP_W-1:0]    src_gp;
    logic [`ID_GP_W-1:0]    tgt_gp;
    logic                   tgt_gp_we;
    logic                   has_src_sr;
    logic [`ID_SR_W-1:0]    src_sr;
    logic [`ID_SR_W-1:0]    tgt_sr;
    logic                   tgt_sr_we;

    integer      seed;
    int unsigned fall_cnt = 0;
    int          cycle_no;
    string       phase;
    out_t        exp_q;
    logic [7:0]  defined_ops[$];

    stg_id uut (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .pc         (pc),
        .instr      (instr),
        .flush      (flush),
        .stall      (stall),
        .pc_q       (pc_q),
        .instr_q    (instr_q),
        .opc        (opc),
        .sgn_en     (sgn_en),
        .imm_en     (imm_en),
        .imm12_val  (imm12_val),
        .imm14_val  (imm14_val),
        .imm16_val  (imm16_val),
        .cc         (cc),
        .has_src_gp (has_src_gp),
        .src_gp     (src_gp),
        .tgt_gp     (tgt_gp),
        .tgt_gp_we  (tgt_gp_we),
        .has_src_sr (has_src_sr),
        .src_sr     (src_sr),
        .tgt_sr     (tgt_sr),
        .tgt_sr_we  (tgt_sr_we)
    );

    // Clock, with a count of falling edges for the polling waits
    initial begin
        iw_clk = 1'b0;
        forever begin
            #20 iw_clk = 1'b1;
            #20 iw_clk = 1'b0;
            fall_cnt++;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at cycle %0d", cycle_no);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s/%s: expected %h, actual %h (cycle %0d)",
                                        phase, name, expected, actual, cycle_no));
        end
    endtask

    // Polls on half-nanosecond offsets, never on a clock edge
    task automatic wait_fall;
        int unsigned start;
        int          polls;
        start = fall_cnt;
        polls = 0;
        while (fall_cnt == start) begin
            if (polls >= POLL_LIMIT) begin
                stop_with_failure("Timeout: no falling clock edge arrived in time");
            end
            #1;
            polls++;
        end
    endtask

    function automatic logic is_defined(input logic [7:0] op);
        case (op[7:4])
            4'h0:       return op[3:0] <= 4'hD;
            4'h1:       return op[3:0] <= 4'hB;
            4'h2, 4'h3: return op[3:0] <= 4'h5;
            4'h4:       return op[3:0] <= 4'h3;
            4'h5:       return op[3:0] <= 4'h4;
            4'h6:       return op[3:0] <= 4'h1;
            default:    return 1'b0;
        endcase
    endfunction

    // Reference decode built from the opcode class and the per-opcode exceptions
    function automatic out_t decode_model(input logic [`ID_ADDR_W-1:0] pc_v,
                                          input logic [`ID_DATA_W-1:0] instr_v);
        out_t       o;
        logic [7:0] op;
        logic [3:0] cls;
        logic       ok;
        logic       flags;
        logic       has_tgt_gp;
        logic       has_tgt_sr;
        o = '0;
        op = instr_v[`ID_OPC_HI:`ID_OPC_LO];
        cls = op[7:4];
        ok = is_defined(op);
        o.pc_q = pc_v;
        o.instr_q = instr_v;
        o.opc = op;
        o.sgn_en = ok && (cls == 4'h2 || cls == 4'h3 || op inside {id_pkg::BCCsr,
            id_pkg::BCCso, id_pkg::BALso, id_pkg::SRADDsi, id_pkg::SRSUBsi,
            id_pkg::SRLDso, id_pkg::SRSTso});
        o.imm_en = ok && (cls == 4'h1 || cls == 4'h3 || op inside {id_pkg::JCCui,
            id_pkg::BCCso, id_pkg::BALso, id_pkg::SRADDsi, id_pkg::SRSUBsi,
            id_pkg::SRLDso, id_pkg::SRSTso, id_pkg::SYSCALL});
        flags = ok && (cls == 4'h4 || op inside {id_pkg::MCCur, id_pkg::MCCsi});
        o.tgt_gp_we = ok && ((cls == 4'h0 && !(op inside {id_pkg::CMPur, id_pkg::TSTur}))
            || (cls == 4'h1 && op != id_pkg::CMPui)
            || (cls == 4'h2 && !(op inside {id_pkg::CMPsr, id_pkg::TSTsr}))
            || (cls == 4'h3 && op != id_pkg::CMPsi));
        has_tgt_gp = o.tgt_gp_we || op inside {id_pkg::CMPur, id_pkg::CMPui,
            id_pkg::CMPsr, id_pkg::TSTur, id_pkg::TSTsr, id_pkg::BCCsr};
        o.has_src_gp = (ok && cls == 4'h0 && !(op inside {id_pkg::NOTur, id_pkg::TSTur}))
            || op inside {id_pkg::ADDsr, id_pkg::SUBsr, id_pkg::SHRsr, id_pkg::CMPsr};
        o.has_src_sr = flags || op inside {id_pkg::SRMOVur, id_pkg::SRLDso, id_pkg::SRSTso};
        o.tgt_sr_we = op inside {id_pkg::SRMOVur, id_pkg::SRADDsi, id_pkg::SRSUBsi,
            id_pkg::SRLDso, id_pkg::SYSCALL};
        has_tgt_sr = o.tgt_sr_we || op == id_pkg::SRSTso;
        if (ok && (cls == 4'h1 || cls == 4'h3 || op inside {id_pkg::JCCui, id_pkg::BCCso,
                id_pkg::SRLDso, id_pkg::SRSTso, id_pkg::SYSCALL})) begin
            o.imm12_val = instr_v[11:0];
        end
        if (op inside {id_pkg::SRADDsi, id_pkg::SRSUBsi}) begin
            o.imm14_val = instr_v[13:0];
        end
        if (op == id_pkg::BALso) begin
            o.imm16_val = instr_v[15:0];
        end
        if (op inside {id_pkg::JCCui, id_pkg::BCCso}) begin
            o.cc = instr_v[15:12];
        end else if (op inside {id_pkg::BCCsr, id_pkg::MCCsi}) begin
            o.cc = instr_v[11:8];
        end else if (op == id_pkg::MCCur) begin
            o.cc = instr_v[7:4];
        end
        o.tgt_gp = has_tgt_gp ? instr_v[15:12] : '0;
        o.src_gp = instr_v[11:8];
        o.src_sr = flags ? FL_IDX : instr_v[13:12];
        if (op inside {id_pkg::SYSCALL, id_pkg::KRET}) begin
            o.tgt_sr = LR_IDX;
        end else if (has_tgt_sr) begin
            o.tgt_sr = instr_v[15:14];
        end
        return o;
    endfunction

    // Register copy: flush first, then stall, then load
    function automatic out_t model_next(input out_t cur,
                                        input logic [`ID_ADDR_W-1:0] pc_v,
                                        input logic [`ID_DATA_W-1:0] instr_v,
                                        input logic flush_v, input logic stall_v);
        if (flush_v) begin
            return '0;
        end
        if (stall_v) begin
            return cur;
        end
        return decode_model(pc_v, instr_v);
    endfunction

    task automatic check_outputs;
        check("pc_q", exp_q.pc_q, pc_q);
        check("instr_q", exp_q.instr_q, instr_q);
        check("opc", exp_q.opc, opc);
        check("sgn_en", exp_q.sgn_en, sgn_en);
        check("imm_en", exp_q.imm_en, imm_en);
        check("imm12_val", exp_q.imm12_val, imm12_val);
        check("imm14_val", exp_q.imm14_val, imm14_val);
        check("imm16_val", exp_q.imm16_val, imm16_val);
        check("cc", exp_q.cc, cc);
        check("has_src_gp", exp_q.has_src_gp, has_src_gp);
        check("src_gp", exp_q.src_gp, src_gp);
        check("tgt_gp", exp_q.tgt_gp, tgt_gp);
        check("tgt_gp_we", exp_q.tgt_gp_we, tgt_gp_we);
        check("has_src_sr", exp_q.has_src_sr, has_src_sr);
        check("src_sr", exp_q.src_sr, src_sr);
        check("tgt_sr", exp_q.tgt_sr, tgt_sr);
        check("tgt_sr_we", exp_q.tgt_sr_we, tgt_sr_we);
        if (uut.u_assert.error_count != 0) begin
            stop_with_failure("An assertion on the stage registers failed");
        end
    endtask

    // Check what the last rising edge latched, then drive the next inputs
    task automatic run_cycle(input logic [`ID_ADDR_W-1:0] pc_v,
                             input logic [`ID_DATA_W-1:0] instr_v,
                             input logic flush_v, input logic stall_v);
        wait_fall();
        cycle_no++;
        check_outputs();
        pc = pc_v;
        instr = instr_v;
        flush = flush_v;
        stall = stall_v;
        exp_q = model_next(exp_q, pc_v, instr_v, flush_v, stall_v);
    endtask

    initial begin
        int                    i;
        logic [31:0]           r;
        logic [7:0]            op;
        logic [15:0]           low;
        logic [`ID_ADDR_W-1:0] pc_r;
        logic                  fl;
        logic                  st;
        pc = '0;
        instr = '0;
        flush = 1'b0;
        stall = 1'b0;
        iw_rst = 1'b0;
        seed = 32'hc3b3edf8;
        cycle_no = 0;
        exp_q = '0;
        phase = "reset";
        for (i = 0; i < 256; i++) begin
            if (is_defined(i[7:0])) begin
                defined_ops.push_back(i[7:0]);
            end
        end

        // Raise reset slightly after time zero so the asynchronous edge is seen
        #0.5;
        iw_rst = 1'b1;
        for (i = 0; i < 8; i++) begin
            wait_fall();
            cycle_no++;
            check_outputs();
        end
        iw_rst = 1'b0;
        exp_q = model_next(exp_q, pc, instr, flush, stall);

        phase = "random";
        for (i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            if (r[1:0] != 2'b00) begin
                op = defined_ops[$unsigned($random(seed)) % defined_ops.size()];
            end else begin
                op = r[15:8];
            end
            low = $random(seed);
            pc_r = $random(seed);
            fl = ($unsigned($random(seed)) % 10) == 0;
            st = ($unsigned($random(seed)) % 10) == 0;
            run_cycle(pc_r, {op, low}, fl, st);
        end

        // Long stall, then the held word must give way to the next one
        phase = "stall";
        run_cycle(24'h000100, {id_pkg::BCCso, 16'hA5C3}, 1'b0, 1'b0);
        for (i = 0; i < 4; i++) begin
            run_cycle(24'h000104, {id_pkg::ADDsi, 16'h1234}, 1'b0, 1'b1);
        end
        run_cycle(24'h000108, {id_pkg::SRSTso, 16'hC0DE}, 1'b0, 1'b0);

        phase = "flush";
        run_cycle(24'h00010C, {id_pkg::SYSCALL, 16'h0FFF}, 1'b1, 1'b1);
        run_cycle(24'h000110, {id_pkg::KRET, 16'h4321}, 1'b0, 1'b0);

        phase = "undefined";
        run_cycle(24'h00ABCD, {8'h7E, 16'hFFFF}, 1'b0, 1'b0);
        run_cycle(24'h00ABD0, {8'hF1, 16'h5A5A}, 1'b0, 1'b0);
        run_cycle(24'h000000, 24'h000000, 1'b0, 1'b0);

        // The last word still has to come out of the stage
        wait_fall();
        cycle_no++;
        check_outputs();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/id_pkg.sv
src/id_classify.sv
src/id_fields.sv
src/id_stage_reg.sv
src/stg_id.sv
verification/stg_id_assert.sv
verification/tb_stg_id.sv

/* Bender.yml */
package:
  name: stg_id

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/id_pkg.sv
      - src/id_classify.sv
      - src/id_fields.sv
      - src/id_stage_reg.sv
      - src/stg_id.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/stg_id_assert.sv
      - verification/tb_stg_id.sv
